// File: Makefile
VERILATOR = verilator
TOP = tb_bru_iq
FLIST = flist.f
FLAGS = --binary --timing --assert -j 0 --top-module $(TOP)
OBJ_DIR = obj_dir
BIN = $(OBJ_DIR)/V$(TOP)
LOG = sim.log
SRCS = core_types_pkg.sv operand_wakeup.sv oldest_ready_select.sv bru_iq.sv \
	bru_iq_wrapper.sv bru_iq_checker.sv tb_bru_iq.sv

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN) bru_iq_stimulus.txt
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bru_iq.sv
`timescale 1ns/1ps

module bru_iq #(
	parameter int BRU_IQ_ENTRIES = 6,
	parameter int FAST_FORWARD_PIPE_COUNT = 4,
	localparam int IDX_WIDTH = $clog2(BRU_IQ_ENTRIES)
) (
	input logic CLK,
	input logic nRST,

	// enqueue
	input core_types_pkg::bru_enq_op_t iq_enq,
	output logic iq_enq_ready,

	// wakeups
	input logic [core_types_pkg::PRF_BANK_COUNT-1:0] wb_bus_valid_by_bank,
	input core_types_pkg::upper_pr_t [core_types_pkg::PRF_BANK_COUNT-1:0] wb_bus_upper_pr_by_bank,
	input logic [FAST_FORWARD_PIPE_COUNT-1:0] ff_valid_by_pipe,
	input core_types_pkg::pr_t [FAST_FORWARD_PIPE_COUNT-1:0] ff_pr_by_pipe,

	// issue to pipeline
	output core_types_pkg::bru_issue_op_t issue,
	input logic issue_ready,

	// register reads
	output core_types_pkg::prf_req_t prf_req_a,
	output core_types_pkg::prf_req_t prf_req_b
);

	// entry array, index 0 oldest, valid entries packed at the bottom
	core_types_pkg::bru_enq_op_t entry_q [BRU_IQ_ENTRIES];
	core_types_pkg::bru_enq_op_t updated [BRU_IQ_ENTRIES];
	core_types_pkg::bru_enq_op_t shifted [BRU_IQ_ENTRIES];
	core_types_pkg::bru_enq_op_t next_entry [BRU_IQ_ENTRIES];

	logic [BRU_IQ_ENTRIES-1:0] a_available;
	logic [BRU_IQ_ENTRIES-1:0] b_available;
	logic [BRU_IQ_ENTRIES-1:0] a_set_ready;
	logic [BRU_IQ_ENTRIES-1:0] b_set_ready;
	core_types_pkg::operand_src_t a_src [BRU_IQ_ENTRIES];
	core_types_pkg::operand_src_t b_src [BRU_IQ_ENTRIES];

	logic [BRU_IQ_ENTRIES-1:0] req;
	logic [BRU_IQ_ENTRIES-1:0] first_free;
	logic sel_found;
	logic [IDX_WIDTH-1:0] sel_idx;
	logic issue_fire;
	logic enq_accept;
	core_types_pkg::bru_enq_op_t sel_entry;

	// ----------------------------------------------------------
	// per entry wakeup
	// ----------------------------------------------------------

	for (genvar i = 0; i < BRU_IQ_ENTRIES; i++) begin : g_entry
		operand_wakeup #(
			.FAST_FORWARD_PIPE_COUNT(FAST_FORWARD_PIPE_COUNT)
		) a_wakeup (
			.stored_pr(entry_q[i].a_pr),
			.stored_ready(entry_q[i].a_ready),
			.stored_unneeded(entry_q[i].a_unneeded),
			.wb_valid_by_bank(wb_bus_valid_by_bank),
			.wb_upper_pr_by_bank(wb_bus_upper_pr_by_bank),
			.ff_valid_by_pipe(ff_valid_by_pipe),
			.ff_pr_by_pipe(ff_pr_by_pipe),
			.available(a_available[i]),
			.set_ready(a_set_ready[i]),
			.src(a_src[i])
		);

		operand_wakeup #(
			.FAST_FORWARD_PIPE_COUNT(FAST_FORWARD_PIPE_COUNT)
		) b_wakeup (
			.stored_pr(entry_q[i].b_pr),
			.stored_ready(entry_q[i].b_ready),
			.stored_unneeded(entry_q[i].b_unneeded),
			.wb_valid_by_bank(wb_bus_valid_by_bank),
			.wb_upper_pr_by_bank(wb_bus_upper_pr_by_bank),
			.ff_valid_by_pipe(ff_valid_by_pipe),
			.ff_pr_by_pipe(ff_pr_by_pipe),
			.available(b_available[i]),
			.set_ready(b_set_ready[i]),
			.src(b_src[i])
		);

		assign req[i] = entry_q[i].valid & a_available[i] & b_available[i];

		// wakeups land in the stored ready bits whether or not we issue
		always_comb begin
			updated[i] = entry_q[i];
			updated[i].a_ready = entry_q[i].a_ready | a_set_ready[i];
			updated[i].b_ready = entry_q[i].b_ready | b_set_ready[i];
		end
	end

	// ----------------------------------------------------------
	// issue select
	// ----------------------------------------------------------

	oldest_ready_select #(
		.BRU_IQ_ENTRIES(BRU_IQ_ENTRIES)
	) select_inst (
		.req(req),
		.found(sel_found),
		.index(sel_idx)
	);

	assign issue_fire = sel_found & issue_ready;
	assign sel_entry = entry_q[sel_idx];

	always_comb begin
		issue.valid = issue_fire;
		issue.op = sel_entry.op;
		issue.pred_info = sel_entry.pred_info;
		issue.pred_lru = sel_entry.pred_lru;
		issue.is_link_ra = sel_entry.is_link_ra;
		issue.is_ret_ra = sel_entry.is_ret_ra;
		issue.pc = sel_entry.pc;
		issue.pred_pc = sel_entry.pred_pc;
		issue.imm20 = sel_entry.imm20;
		issue.a_src = a_src[sel_idx];
		issue.b_src = b_src[sel_idx];
		issue.dest_pr = sel_entry.dest_pr;
		issue.rob_index = sel_entry.rob_index;
	end

	// read ports only for operands that come from the register file
	assign prf_req_a.valid = issue_fire & issue.a_src.is_reg;
	assign prf_req_a.pr = sel_entry.a_pr;
	assign prf_req_b.valid = issue_fire & issue.b_src.is_reg;
	assign prf_req_b.pr = sel_entry.b_pr;

	// ----------------------------------------------------------
	// compaction and enqueue
	// ----------------------------------------------------------

	// top slot empty means at least one free entry
	assign iq_enq_ready = ~entry_q[BRU_IQ_ENTRIES-1].valid;
	assign enq_accept = iq_enq.valid & iq_enq_ready;

	for (genvar i = 0; i < BRU_IQ_ENTRIES; i++) begin : g_shift
		if (i < BRU_IQ_ENTRIES - 1) begin : g_lower
			assign shifted[i] = (issue_fire && (IDX_WIDTH'(i) >= sel_idx)) ?
				updated[i+1] : updated[i];
		end else begin : g_top
			// any issue frees the top slot
			assign shifted[i] = issue_fire ? core_types_pkg::bru_enq_op_t'('0) : updated[i];
		end

		if (i == 0) begin : g_first
			assign first_free[i] = ~shifted[i].valid;
		end else begin : g_rest
			assign first_free[i] = ~shifted[i].valid & shifted[i-1].valid;
		end

		assign next_entry[i] = (enq_accept && first_free[i]) ? iq_enq : shifted[i];
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			for (int i = 0; i < BRU_IQ_ENTRIES; i++) begin
				entry_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < BRU_IQ_ENTRIES; i++) begin
				entry_q[i] <= next_entry[i];
			end
		end
	end

endmodule

// File: bru_iq_checker.sv
`timescale 1ns/1ps

module bru_iq_checker (
	input logic CLK,
	input logic nRST,
	input logic next_issue_ready,
	input logic last_iq_enq_ready,
	input core_types_pkg::bru_issue_op_t last_issue,
	input core_types_pkg::prf_req_t last_prf_req_a,
	input core_types_pkg::prf_req_t last_prf_req_b
);

	// ready low sampled at E gates the queue until E+1, output lands at E+1
	a_no_issue_when_blocked: assert property (@(posedge CLK) disable iff (!nRST)
		!next_issue_ready |-> ##2 !last_issue.valid)
		else $error("issue seen while the pipeline was not ready");

	a_prf_needs_issue: assert property (@(posedge CLK) disable iff (!nRST)
		(last_prf_req_a.valid || last_prf_req_b.valid) |-> last_issue.valid)
		else $error("register read request without an issue");

	a_outputs_known: assert property (@(posedge CLK) disable iff (!nRST)
		!$isunknown({last_iq_enq_ready, last_issue, last_prf_req_a, last_prf_req_b}))
		else $error("unknown value on a queue output");

endmodule

bind bru_iq_wrapper bru_iq_checker bru_iq_checker_inst (
	.CLK(CLK),
	.nRST(nRST),
	.next_issue_ready(next_issue_ready),
	.last_iq_enq_ready(last_iq_enq_ready),
	.last_issue(last_issue),
	.last_prf_req_a(last_prf_req_a),
	.last_prf_req_b(last_prf_req_b)
);

// File: bru_iq_stimulus.txt
# E op pc rob a_pr a_rdy a_unn b_pr b_rdy b_unn | B bank upper | F pipe pr
# R ready | I cycles | K enq_ready | Z | X op pc rob a_pr a_reg a_bus a_ff a_pipe b_pr ... wait
Z
K 1
# both operands ready, two edge latency
E 3 00001000 1 5 1 0 6 1 0
X 3 00001000 1 5 1 0 0 0 6 1 0 0 0 2
Z
# A wakes from the bus, register 9 is bank 1 upper 2
E 1 00001010 2 9 0 0 7 1 0
I 2
Z
B 1 2
X 1 00001010 2 9 0 1 0 0 7 1 0 0 0 0
# B wakes from fast forward pipe 2
E 2 00001020 3 10 1 0 14 0 0
I 2
F 2 14
X 2 00001020 3 10 1 0 0 0 14 0 0 1 2 0
# older waiting op does not block younger ready ones
E 4 00001030 4 20 0 0 21 1 0
E 5 00001040 5 22 1 0 23 1 0
E 6 00001050 6 24 1 0 25 1 0
X 5 00001040 5 22 1 0 0 0 23 1 0 0 0 0
X 6 00001050 6 24 1 0 0 0 25 1 0 0 0 0
B 0 5
X 4 00001030 4 20 0 1 0 0 21 1 0 0 0 0
# back pressure, fill the queue
R 0
E 8 00002000 10 40 1 0 50 1 0
I 1
E 8 00002010 11 41 1 0 51 1 0
I 1
E 8 00002020 12 42 1 0 30 0 0
I 1
E 8 00002030 13 43 1 0 53 1 0
I 1
E 8 00002040 14 44 1 0 54 1 0
I 1
K 1
E 8 00002050 15 45 1 0 55 1 0
I 2
K 0
Z
F 1 30
I 2
Z
R 1
X 8 00002000 10 40 1 0 0 0 50 1 0 0 0 0
X 8 00002010 11 41 1 0 0 0 51 1 0 0 0 0
X 8 00002020 12 42 1 0 0 0 30 1 0 0 0 0
X 8 00002030 13 43 1 0 0 0 53 1 0 0 0 0
X 8 00002040 14 44 1 0 0 0 54 1 0 0 0 0
X 8 00002050 15 45 1 0 0 0 55 1 0 0 0 0
I 2
K 1
# unneeded A operand
E 7 00001100 20 33 0 1 34 1 0
X 7 00001100 20 33 0 0 0 0 34 1 0 0 0 2
Z

// File: bru_iq_wrapper.sv
`timescale 1ns/1ps

module bru_iq_wrapper #(
	parameter int BRU_IQ_ENTRIES = 6,
	parameter int FAST_FORWARD_PIPE_COUNT = 4
) (
	input logic CLK,
	input logic nRST,

	// enqueue
	input core_types_pkg::bru_enq_op_t next_iq_enq,
	output logic last_iq_enq_ready,

	// writeback bus by bank
	input logic [core_types_pkg::PRF_BANK_COUNT-1:0] next_wb_bus_valid_by_bank,
	input core_types_pkg::upper_pr_t [core_types_pkg::PRF_BANK_COUNT-1:0]
		next_wb_bus_upper_pr_by_bank,

	// fast forward notifications by pipe
	input logic [FAST_FORWARD_PIPE_COUNT-1:0] next_ff_valid_by_pipe,
	input core_types_pkg::pr_t [FAST_FORWARD_PIPE_COUNT-1:0] next_ff_pr_by_pipe,

	// issue
	output core_types_pkg::bru_issue_op_t last_issue,
	input logic next_issue_ready,

	// register reads
	output core_types_pkg::prf_req_t last_prf_req_a,
	output core_types_pkg::prf_req_t last_prf_req_b
);

	// ----------------------------------------------------------
	// queue side signals
	// ----------------------------------------------------------

	core_types_pkg::bru_enq_op_t iq_enq;
	logic iq_enq_ready;
	logic [core_types_pkg::PRF_BANK_COUNT-1:0] wb_bus_valid_by_bank;
	core_types_pkg::upper_pr_t [core_types_pkg::PRF_BANK_COUNT-1:0] wb_bus_upper_pr_by_bank;
	logic [FAST_FORWARD_PIPE_COUNT-1:0] ff_valid_by_pipe;
	core_types_pkg::pr_t [FAST_FORWARD_PIPE_COUNT-1:0] ff_pr_by_pipe;
	core_types_pkg::bru_issue_op_t issue;
	logic issue_ready;
	core_types_pkg::prf_req_t prf_req_a;
	core_types_pkg::prf_req_t prf_req_b;

	bru_iq #(
		.BRU_IQ_ENTRIES(BRU_IQ_ENTRIES),
		.FAST_FORWARD_PIPE_COUNT(FAST_FORWARD_PIPE_COUNT)
	) bru_iq_inst (
		.CLK(CLK),
		.nRST(nRST),
		.iq_enq(iq_enq),
		.iq_enq_ready(iq_enq_ready),
		.wb_bus_valid_by_bank(wb_bus_valid_by_bank),
		.wb_bus_upper_pr_by_bank(wb_bus_upper_pr_by_bank),
		.ff_valid_by_pipe(ff_valid_by_pipe),
		.ff_pr_by_pipe(ff_pr_by_pipe),
		.issue(issue),
		.issue_ready(issue_ready),
		.prf_req_a(prf_req_a),
		.prf_req_b(prf_req_b)
	);

	// ----------------------------------------------------------
	// one register stage on every port
	// ----------------------------------------------------------

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			// inputs
			iq_enq <= '0;
			wb_bus_valid_by_bank <= '0;
			wb_bus_upper_pr_by_bank <= '0;
			ff_valid_by_pipe <= '0;
			ff_pr_by_pipe <= '0;
			issue_ready <= 1'b0;

			// outputs
			last_iq_enq_ready <= 1'b0;
			last_issue <= '0;
			last_prf_req_a <= '0;
			last_prf_req_b <= '0;
		end else begin
			iq_enq <= next_iq_enq;
			wb_bus_valid_by_bank <= next_wb_bus_valid_by_bank;
			wb_bus_upper_pr_by_bank <= next_wb_bus_upper_pr_by_bank;
			ff_valid_by_pipe <= next_ff_valid_by_pipe;
			ff_pr_by_pipe <= next_ff_pr_by_pipe;
			issue_ready <= next_issue_ready;

			// ready lags the queue state by one edge
			last_iq_enq_ready <= iq_enq_ready;
			last_issue <= issue;
			last_prf_req_a <= prf_req_a;
			last_prf_req_b <= prf_req_b;
		end
	end

endmodule

// File: core_types_pkg.sv
package core_types_pkg;

	// ----------------------------------------------------------
	// core widths
	// ----------------------------------------------------------

	localparam int PR_COUNT = 64;
	localparam int LOG_PR_COUNT = $clog2(PR_COUNT);

	// bank is the low bits of the register number
	localparam int PRF_BANK_COUNT = 4;
	localparam int LOG_PRF_BANK_COUNT = $clog2(PRF_BANK_COUNT);

	localparam int LOG_ROB_ENTRIES = 6;

	// pipe select sized for up to 4 fast forward pipes
	localparam int LOG_FF_PIPE_WIDTH = 2;

	typedef logic [LOG_PR_COUNT-1:0] pr_t;
	typedef logic [LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper_pr_t;
	typedef logic [LOG_PRF_BANK_COUNT-1:0] bank_t;
	typedef logic [LOG_ROB_ENTRIES-1:0] rob_idx_t;
	typedef logic [LOG_FF_PIPE_WIDTH-1:0] ff_pipe_t;
	typedef logic [3:0] bru_op_t;
	typedef logic [7:0] pred_info_t;
	typedef logic [31:0] pc_t;
	typedef logic [19:0] imm20_t;

	// ----------------------------------------------------------
	// enqueue and issue bundles
	// ----------------------------------------------------------

	typedef struct packed {
		logic valid;
		bru_op_t op;
		pred_info_t pred_info;
		logic pred_lru;
		logic is_link_ra;
		logic is_ret_ra;
		pc_t pc;
		pc_t pred_pc;
		imm20_t imm20;
		pr_t a_pr;
		logic a_ready;
		logic a_unneeded;
		pr_t b_pr;
		logic b_ready;
		logic b_unneeded;
		pr_t dest_pr;
		rob_idx_t rob_index;
	} bru_enq_op_t;

	// where the execute pipe picks up an operand
	typedef struct packed {
		logic is_reg;
		logic is_bus_forward;
		logic is_fast_forward;
		ff_pipe_t fast_forward_pipe;
		bank_t bank;
	} operand_src_t;

	typedef struct packed {
		logic valid;
		bru_op_t op;
		pred_info_t pred_info;
		logic pred_lru;
		logic is_link_ra;
		logic is_ret_ra;
		pc_t pc;
		pc_t pred_pc;
		imm20_t imm20;
		operand_src_t a_src;
		operand_src_t b_src;
		pr_t dest_pr;
		rob_idx_t rob_index;
	} bru_issue_op_t;

	typedef struct packed {
		logic valid;
		pr_t pr;
	} prf_req_t;

endpackage

// File: flist.f
core_types_pkg.sv
operand_wakeup.sv
oldest_ready_select.sv
bru_iq.sv
bru_iq_wrapper.sv
bru_iq_checker.sv
tb_bru_iq.sv

// File: oldest_ready_select.sv
`timescale 1ns/1ps

module oldest_ready_select #(
	parameter int BRU_IQ_ENTRIES = 6,
	localparam int IDX_WIDTH = $clog2(BRU_IQ_ENTRIES)
) (
	input logic [BRU_IQ_ENTRIES-1:0] req,
	output logic found,
	output logic [IDX_WIDTH-1:0] index
);

	// ----------------------------------------------------------
	// priority encode, entry 0 is the oldest
	// ----------------------------------------------------------

	always_comb begin
		found = 1'b0;
		index = '0;
		for (int i = BRU_IQ_ENTRIES - 1; i >= 0; i--) begin
			if (req[i]) begin
				found = 1'b1;
				index = IDX_WIDTH'(i);
			end
		end
	end

endmodule

// File: operand_wakeup.sv
`timescale 1ns/1ps

module operand_wakeup #(
	parameter int FAST_FORWARD_PIPE_COUNT = 4
) (
	input core_types_pkg::pr_t stored_pr,
	input logic stored_ready,
	input logic stored_unneeded,
	input logic [core_types_pkg::PRF_BANK_COUNT-1:0] wb_valid_by_bank,
	input core_types_pkg::upper_pr_t [core_types_pkg::PRF_BANK_COUNT-1:0] wb_upper_pr_by_bank,
	input logic [FAST_FORWARD_PIPE_COUNT-1:0] ff_valid_by_pipe,
	input core_types_pkg::pr_t [FAST_FORWARD_PIPE_COUNT-1:0] ff_pr_by_pipe,
	output logic available,
	output logic set_ready,
	output core_types_pkg::operand_src_t src
);

	core_types_pkg::bank_t bank;
	core_types_pkg::upper_pr_t upper;
	logic waiting;
	logic bus_hit;
	logic [FAST_FORWARD_PIPE_COUNT-1:0] ff_hit;
	logic ff_any;
	core_types_pkg::ff_pipe_t ff_pipe;

	assign bank = stored_pr[core_types_pkg::LOG_PRF_BANK_COUNT-1:0];
	assign upper = stored_pr[core_types_pkg::LOG_PR_COUNT-1:core_types_pkg::LOG_PRF_BANK_COUNT];

	// only the lane of our own bank can carry this register
	assign bus_hit = wb_valid_by_bank[bank] && (wb_upper_pr_by_bank[bank] == upper);

	always_comb begin
		for (int p = 0; p < FAST_FORWARD_PIPE_COUNT; p++) begin
			ff_hit[p] = ff_valid_by_pipe[p] && (ff_pr_by_pipe[p] == stored_pr);
		end
	end

	// walk down so the lowest matching pipe wins
	always_comb begin
		ff_any = 1'b0;
		ff_pipe = '0;
		for (int p = FAST_FORWARD_PIPE_COUNT - 1; p >= 0; p--) begin
			if (ff_hit[p]) begin
				ff_any = 1'b1;
				ff_pipe = core_types_pkg::ff_pipe_t'(p);
			end
		end
	end

	assign waiting = ~stored_ready & ~stored_unneeded;

	assign available = stored_ready | stored_unneeded | bus_hit | ff_any;
	assign set_ready = waiting & (bus_hit | ff_any);

	// one source at most, bus preferred over fast forward
	assign src.is_reg = stored_ready & ~stored_unneeded;
	assign src.is_bus_forward = waiting & bus_hit;
	assign src.is_fast_forward = waiting & ~bus_hit & ff_any;
	assign src.fast_forward_pipe = src.is_fast_forward ? ff_pipe : '0;
	assign src.bank = bank;

endmodule

// File: tb_bru_iq.sv
`timescale 1ns/1ps

module tb_bru_iq;

	localparam int BRU_IQ_ENTRIES = 6;
	localparam int FAST_FORWARD_PIPE_COUNT = 4;
	localparam int WAIT_LIMIT = 40;

	logic CLK;
	logic nRST;
	core_types_pkg::bru_enq_op_t next_iq_enq;
	logic last_iq_enq_ready;
	logic [core_types_pkg::PRF_BANK_COUNT-1:0] next_wb_bus_valid_by_bank;
	core_types_pkg::upper_pr_t [core_types_pkg::PRF_BANK_COUNT-1:0] next_wb_bus_upper_pr_by_bank;
	logic [FAST_FORWARD_PIPE_COUNT-1:0] next_ff_valid_by_pipe;
	core_types_pkg::pr_t [FAST_FORWARD_PIPE_COUNT-1:0] next_ff_pr_by_pipe;
	core_types_pkg::bru_issue_op_t last_issue;
	logic next_issue_ready;
	core_types_pkg::prf_req_t last_prf_req_a;
	core_types_pkg::prf_req_t last_prf_req_b;

	int errors;
	int checks;
	logic timed_out;

	bru_iq_wrapper #(
		.BRU_IQ_ENTRIES(BRU_IQ_ENTRIES),
		.FAST_FORWARD_PIPE_COUNT(FAST_FORWARD_PIPE_COUNT)
	) bru_iq_wrapper_inst (
		.CLK(CLK),
		.nRST(nRST),
		.next_iq_enq(next_iq_enq),
		.last_iq_enq_ready(last_iq_enq_ready),
		.next_wb_bus_valid_by_bank(next_wb_bus_valid_by_bank),
		.next_wb_bus_upper_pr_by_bank(next_wb_bus_upper_pr_by_bank),
		.next_ff_valid_by_pipe(next_ff_valid_by_pipe),
		.next_ff_pr_by_pipe(next_ff_pr_by_pipe),
		.last_issue(last_issue),
		.next_issue_ready(next_issue_ready),
		.last_prf_req_a(last_prf_req_a),
		.last_prf_req_b(last_prf_req_b)
	);

	initial CLK = 1'b0;
	always #2 CLK = ~CLK;

	// ----------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------

	task automatic check_issue(input string name, input core_types_pkg::bru_issue_op_t exp,
		input core_types_pkg::bru_issue_op_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_prf_req(input string name, input core_types_pkg::prf_req_t exp,
		input core_types_pkg::prf_req_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s expected %b actual %b", name, exp, act);
		end
	endtask

	// side fields follow from the ROB index
	function automatic core_types_pkg::bru_enq_op_t make_enq(input int op, input logic [31:0] pc,
		input int rob, input int a_pr, input int a_rdy, input int a_unn, input int b_pr,
		input int b_rdy, input int b_unn);
		core_types_pkg::bru_enq_op_t e;
		core_types_pkg::rob_idx_t r;
		r = core_types_pkg::rob_idx_t'(rob);
		e = '0;
		e.valid = 1'b1;
		e.op = core_types_pkg::bru_op_t'(op);
		e.pred_info = core_types_pkg::pred_info_t'({2'b00, r} ^ 8'h5a);
		e.pred_lru = r[0];
		e.is_link_ra = r[1];
		e.is_ret_ra = r[2];
		e.pc = pc;
		e.pred_pc = pc + 32'd8;
		e.imm20 = {14'h0, r};
		e.a_pr = core_types_pkg::pr_t'(a_pr);
		e.a_ready = a_rdy[0];
		e.a_unneeded = a_unn[0];
		e.b_pr = core_types_pkg::pr_t'(b_pr);
		e.b_ready = b_rdy[0];
		e.b_unneeded = b_unn[0];
		e.dest_pr = r + 6'd1;
		e.rob_index = r;
		return e;
	endfunction

	function automatic core_types_pkg::operand_src_t make_src(input int pr, input int is_reg,
		input int bus, input int ff, input int pipe);
		core_types_pkg::operand_src_t s;
		core_types_pkg::pr_t p;
		p = core_types_pkg::pr_t'(pr);
		s.is_reg = is_reg[0];
		s.is_bus_forward = bus[0];
		s.is_fast_forward = ff[0];
		s.fast_forward_pipe = core_types_pkg::ff_pipe_t'(pipe);
		// bank is the register's low bits
		s.bank = p[1:0];
		return s;
	endfunction

	// waits for an issue, compares it, then steps past it
	task automatic expect_issue(input string name, input core_types_pkg::bru_issue_op_t exp,
		input core_types_pkg::prf_req_t exp_a, input core_types_pkg::prf_req_t exp_b,
		input int wait_exp);
		int waited;
		waited = 0;
		while (last_issue.valid !== 1'b1 && waited < WAIT_LIMIT) begin
			@(negedge CLK);
			waited++;
		end
		if (last_issue.valid !== 1'b1) begin
			errors++;
			timed_out = 1'b1;
			$display("timeout: no issue seen for %s within %0d cycles", name, WAIT_LIMIT);
		end else begin
			check_issue(name, exp, last_issue);
			check_prf_req({name, " prf a"}, exp_a, last_prf_req_a);
			check_prf_req({name, " prf b"}, exp_b, last_prf_req_b);
			if (wait_exp > 0) begin
				checks++;
				if (waited != wait_exp) begin
					errors++;
					$display("[ERROR] %s latency expected %0d actual %0d", name, wait_exp, waited);
				end
			end
			@(negedge CLK);
		end
	endtask

	// ----------------------------------------------------------
	// file driven stimulus
	// ----------------------------------------------------------

	initial begin
		int fd;
		int lineno;
		int n;
		string line;
		string args;
		string name;
		byte cmd;
		int op, rob, apr, ardy, aunn, bpr, brdy, bunn;
		int areg, abus, aff, apipe, breg, bbus, bff, bpipe, wt, v0, v1;
		logic [31:0] pc;
		core_types_pkg::bru_enq_op_t e;
		core_types_pkg::bru_issue_op_t exp;
		core_types_pkg::prf_req_t exp_a;
		core_types_pkg::prf_req_t exp_b;

		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		lineno = 0;
		nRST = 1'b0;
		next_iq_enq = '0;
		next_wb_bus_valid_by_bank = '0;
		next_wb_bus_upper_pr_by_bank = '0;
		next_ff_valid_by_pipe = '0;
		next_ff_pr_by_pipe = '0;
		next_issue_ready = 1'b1;

		repeat (2) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;
		@(negedge CLK);

		fd = $fopen("bru_iq_stimulus.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the stimulus file bru_iq_stimulus.txt");
		end else begin
			while (!$feof(fd) && !timed_out) begin
				n = $fgets(line, fd);
				lineno++;
				if (n < 2 || line.getc(0) == "#") continue;
				cmd = line.getc(0);
				args = line.substr(1, line.len() - 1);
				name = $sformatf("line %0d", lineno);
				case (cmd)
					"E": begin
						n = $sscanf(args, "%d %h %d %d %d %d %d %d %d", op, pc, rob,
							apr, ardy, aunn, bpr, brdy, bunn);
						e = make_enq(op, pc, rob, apr, ardy, aunn, bpr, brdy, bunn);
						next_iq_enq = e;
						@(negedge CLK);
						next_iq_enq = '0;
					end
					"B": begin
						n = $sscanf(args, "%d %d", v0, v1);
						next_wb_bus_valid_by_bank[v0] = 1'b1;
						next_wb_bus_upper_pr_by_bank[v0] = core_types_pkg::upper_pr_t'(v1);
						@(negedge CLK);
						next_wb_bus_valid_by_bank = '0;
					end
					"F": begin
						n = $sscanf(args, "%d %d", v0, v1);
						next_ff_valid_by_pipe[v0] = 1'b1;
						next_ff_pr_by_pipe[v0] = core_types_pkg::pr_t'(v1);
						@(negedge CLK);
						next_ff_valid_by_pipe = '0;
					end
					"R": begin
						n = $sscanf(args, "%d", v0);
						next_issue_ready = v0[0];
					end
					"I": begin
						n = $sscanf(args, "%d", v0);
						repeat (v0) @(negedge CLK);
					end
					"K": begin
						n = $sscanf(args, "%d", v0);
						check_bit({name, " enq ready"}, v0[0], last_iq_enq_ready);
					end
					"Z": begin
						check_bit({name, " issue valid"}, 1'b0, last_issue.valid);
						check_bit({name, " prf a valid"}, 1'b0, last_prf_req_a.valid);
						check_bit({name, " prf b valid"}, 1'b0, last_prf_req_b.valid);
					end
					"X": begin
						n = $sscanf(args, "%d %h %d %d %d %d %d %d %d %d %d %d %d %d", op, pc,
							rob, apr, areg, abus, aff, apipe, bpr, breg, bbus, bff, bpipe, wt);
						e = make_enq(op, pc, rob, apr, 0, 0, bpr, 0, 0);
						exp = '0;
						exp.valid = 1'b1;
						exp.op = e.op;
						exp.pred_info = e.pred_info;
						exp.pred_lru = e.pred_lru;
						exp.is_link_ra = e.is_link_ra;
						exp.is_ret_ra = e.is_ret_ra;
						exp.pc = e.pc;
						exp.pred_pc = e.pred_pc;
						exp.imm20 = e.imm20;
						exp.a_src = make_src(apr, areg, abus, aff, apipe);
						exp.b_src = make_src(bpr, breg, bbus, bff, bpipe);
						exp.dest_pr = e.dest_pr;
						exp.rob_index = e.rob_index;
						// only operands read from registers raise a request
						exp_a.valid = areg[0];
						exp_a.pr = e.a_pr;
						exp_b.valid = breg[0];
						exp_b.pr = e.b_pr;
						expect_issue({name, " issue"}, exp, exp_a, exp_b, wt);
					end
					default: begin
						errors++;
						$display("unknown command in stimulus file at %s", name);
					end
				endcase
			end
			$fclose(fd);
		end

		repeat (2) @(negedge CLK);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
